//--- camera_dma_capture.f
hw/cam_capture_pkg.sv
hw/dma_fifo_if.sv
hw/capture_control.sv
hw/pixel_formatter.sv
hw/frame_fifo.sv
hw/dma_burst_writer.sv
hw/capture_stats.sv
hw/camera_dma_capture.sv
tb/camera_dma_capture_properties.sv
tb/tb_camera_dma_capture.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the camera DMA capture testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
   --top-module tb_camera_dma_capture \
   -f camera_dma_capture.f -o sim_camera_dma_capture

./obj_dir/sim_camera_dma_capture > sim.log 2>&1 || true
cat sim.log

if ! grep -qF "*** TEST PASSED ***" sim.log; then
   exit 1
fi

//--- tb/tb_camera_dma_capture.sv
////////////////////////////////////////
// Camera DMA capture testbench
// Table of frames, reference model of
// the DMA beats and status counters
////////////////////////////////////////

`timescale 1ns/1ps

module tb_camera_dma_capture import cam_capture_pkg::*; ();

   localparam int DMA_LEN        = 8;
   localparam int PCLK_RATE      = 199;
   localparam int FIFO_DEPTH     = 16;
   localparam int NUM_ENTRIES    = 7;
   localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 400 + 1000;

   typedef struct packed {
      logic       trig;
      logic       cont;
      logic       gray;
      logic       hold;
      logic       capture;
      logic [7:0] pairs;
   } frame_entry_t;

   // trig, cont, gray, hold wready low, expect capture, pixel pairs
   frame_entry_t frames [NUM_ENTRIES] = '{
      '{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 8'd8},
      '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 8'd16},
      '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'd8},
      '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 8'd8},
      '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 8'd16},
      '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 8'd8},
      '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 8'd20}
   };

   logic        mipi_pclk;
   logic        rst_n;
   logic        i_vsync;
   logic        i_valid;
   pixel_pair_t i_r_pix;
   pixel_pair_t i_g_pix;
   pixel_pair_t i_b_pix;
   logic        i_trigger_capture;
   logic        i_continuous_capture;
   logic        i_rgb_gray;
   logic        i_dma_init_done;
   logic        i_dma_wready = 1'b0;
   logic        o_dma_wvalid;
   logic        o_dma_wlast;
   dma_word_t   o_dma_wdata;
   count_t      o_frames_per_second;
   count_t      o_fifo_wcount;
   count_t      o_fifo_rcount;
   logic        o_fifo_overflow;
   logic        o_fifo_underflow;
   logic [2:0]  o_dma_status;

   logic [31:0] lfsr_state = 32'h701bc276;
   dma_word_t   expected_q [$];
   logic        hold_wready = 1'b0;
   logic        ready_bit = 1'b0;
   logic        arm_enable = 1'b0;
   int          arm_count = 0;
   int          bursts_started = 0;
   int          beat_in_burst = 0;
   int          beats_seen = 0;
   int          pairs_captured = 0;
   int          cycle_count = 0;
   // Frame rate reference
   logic        vs_last;
   int          win_timer;
   int          win_frames;
   int          fps_model;

   camera_dma_capture #(
      .DMA_TRANSFER_LENGTH (DMA_LEN),
      .PCLK_RATE           (PCLK_RATE),
      .FIFO_DEPTH          (FIFO_DEPTH)
   ) dut (.*);

   initial begin
      mipi_pclk = 1'b0;
      forever #5 mipi_pclk = ~mipi_pclk;
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   function automatic logic lfsr_bit();
      logic lsb;
      lsb = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) lfsr_state = lfsr_state ^ 32'h80200003;
      return lsb;
   endfunction

   function automatic pixel_t random_byte();
      pixel_t v;
      for (int i = 0; i < 8; i++) begin
         v[i] = lfsr_bit();
      end
      return v;
   endfunction

   // Luma of one pixel with weights summing to 256
   function automatic pixel_t luma(input pixel_t r, input pixel_t g, input pixel_t b);
      int sum;
      sum = int'(GRAY_R_WEIGHT) * r + int'(GRAY_G_WEIGHT) * g + int'(GRAY_B_WEIGHT) * b;
      return pixel_t'(sum >> 8);
   endfunction

   function automatic dma_word_t expected_beat(input pixel_pair_t r, input pixel_pair_t g,
                                              input pixel_pair_t b, input logic gray);
      pixel_t    y0;
      pixel_t    y1;
      rgb_word_t w;
      y0 = luma(r[7:0], g[7:0], b[7:0]);
      y1 = luma(r[15:8], g[15:8], b[15:8]);
      if (gray) w = {y1, y1, y1, y0, y0, y0};
      else w = {b[15:8], g[15:8], r[15:8], b[7:0], g[7:0], r[7:0]};
      return {8'h00, w[47:24], 8'h00, w[23:0]};
   endfunction

   task automatic fail_with(input string msg);
      $display("%s at %0t", msg, $time);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped on first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act) begin
         $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
         $display("*** TEST FAILED ***");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic wait_for_drain();
      while (expected_q.size() != 0) @(negedge mipi_pclk);
   endtask

   task automatic run_frame(input frame_entry_t f);
      pixel_pair_t r;
      pixel_pair_t g;
      pixel_pair_t b;
      int          stored;
      stored = 0;
      if (f.hold) begin
         wait_for_drain();
         @(posedge mipi_pclk);
         hold_wready = 1'b1;
         repeat (2) @(posedge mipi_pclk);
      end
      @(posedge mipi_pclk);
      i_vsync              <= 1'b1;
      i_trigger_capture    <= f.trig;
      i_continuous_capture <= f.cont;
      i_rgb_gray           <= f.gray;
      repeat (6) @(posedge mipi_pclk);
      i_trigger_capture <= 1'b0;
      i_vsync           <= 1'b0;
      repeat (3) @(posedge mipi_pclk);
      for (int p = 0; p < int'(f.pairs); p++) begin
         r = {random_byte(), random_byte()};
         g = {random_byte(), random_byte()};
         b = {random_byte(), random_byte()};
         i_valid <= 1'b1;
         i_r_pix <= r;
         i_g_pix <= g;
         i_b_pix <= b;
         if (f.capture) begin
            pairs_captured++;
            // Under back-pressure only a full FIFO worth survives
            if (!f.hold || stored < FIFO_DEPTH) begin
               expected_q.push_back(expected_beat(r, g, b, f.gray));
               stored++;
            end
         end
         @(posedge mipi_pclk);
      end
      i_valid <= 1'b0;
      repeat (2) @(posedge mipi_pclk);
      arm_enable = 1'b1;
      if (f.hold) begin
         repeat (8) @(posedge mipi_pclk);
         check_value("o_fifo_overflow", 64'd1, 64'(o_fifo_overflow));
         hold_wready = 1'b0;
      end
   endtask

   ////////////////////////////////////////
   // DMA side
   ////////////////////////////////////////

   // Ready bit is drawn at the falling edge and driven on the next rising edge
   always @(negedge mipi_pclk) begin
      if (rst_n && !hold_wready) ready_bit = lfsr_bit();
      else ready_bit = 1'b0;
   end

   always @(posedge mipi_pclk) begin
      i_dma_wready <= ready_bit;
   end

   // New rising edge of DMA ready whenever the writer sits idle
   initial begin
      wait (arm_enable);
      forever begin
         @(negedge mipi_pclk);
         if (!o_dma_status[1]) begin
            @(posedge mipi_pclk);
            i_dma_init_done <= 1'b1;
            arm_count++;
            repeat (4) @(posedge mipi_pclk);
            i_dma_init_done <= 1'b0;
            repeat (4) @(posedge mipi_pclk);
         end
      end
   end

   always @(negedge mipi_pclk) begin
      if (rst_n && o_dma_wvalid) begin
         if (expected_q.size() == 0) begin
            fail_with("DMA beat with no expected data");
         end else begin
            if (beat_in_burst == 0) begin
               if (arm_count <= bursts_started) fail_with("Burst without a new DMA ready edge");
               bursts_started++;
            end
            check_value("o_dma_wdata", expected_q.pop_front(), o_dma_wdata);
            // A beat needs a non-empty FIFO, an active burst and ready
            check_value("o_dma_status", 64'(3'b011), 64'(o_dma_status));
            beat_in_burst++;
            check_value("o_dma_wlast", 64'(beat_in_burst == DMA_LEN), 64'(o_dma_wlast));
            if (beat_in_burst == DMA_LEN) beat_in_burst = 0;
            beats_seen++;
         end
      end
   end

   // Frame rate window of PCLK_RATE+1 clocks
   always @(posedge mipi_pclk) begin
      if (!rst_n) begin
         vs_last    = 1'b0;
         win_timer  = 0;
         win_frames = 0;
         fps_model  = 0;
      end else begin
         if (win_timer == PCLK_RATE) begin
            fps_model  = win_frames + int'(vs_last && !i_vsync);
            win_frames = 0;
            win_timer  = 0;
         end else begin
            win_frames = win_frames + int'(vs_last && !i_vsync);
            win_timer++;
         end
         vs_last = i_vsync;
      end
   end

   always @(posedge mipi_pclk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: DMA output did not drain in time");
         $display("*** TEST FAILED ***");
         $fatal(1, "timeout");
      end
   end

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      rst_n                = 1'b0;
      i_vsync              = 1'b0;
      i_valid              = 1'b0;
      i_r_pix              = '0;
      i_g_pix              = '0;
      i_b_pix              = '0;
      i_trigger_capture    = 1'b0;
      i_continuous_capture = 1'b0;
      i_rgb_gray           = 1'b0;
      i_dma_init_done      = 1'b0;
      repeat (5) @(posedge mipi_pclk);
      rst_n <= 1'b1;
      repeat (4) @(posedge mipi_pclk);
      for (int e = 0; e < NUM_ENTRIES; e++) begin
         run_frame(frames[e]);
      end
      wait_for_drain();
      repeat (5) @(negedge mipi_pclk);
      check_value("o_fifo_wcount", 64'(pairs_captured), 64'(o_fifo_wcount));
      check_value("o_fifo_rcount", 64'(beats_seen), 64'(o_fifo_rcount));
      check_value("o_frames_per_second", 64'(fps_model), 64'(o_frames_per_second));
      check_value("o_fifo_overflow", 64'd1, 64'(o_fifo_overflow));
      check_value("o_fifo_underflow", 64'd0, 64'(o_fifo_underflow));
      // FIFO reports empty once everything is drained
      check_value("o_dma_status[2]", 64'd1, 64'(o_dma_status[2]));
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

//--- tb/camera_dma_capture_properties.sv
////////////////////////////////////////
// DMA handshake properties
// Bound into the capture top level
////////////////////////////////////////

`timescale 1ns/1ps

module camera_dma_capture_properties import cam_capture_pkg::*; (
   input logic      mipi_pclk,
   input logic      rst_n,
   input logic      i_wvalid,
   input logic      i_wready,
   input logic      i_wlast,
   input dma_word_t i_wdata,
   input logic      i_empty
);

   // Valid is only raised while the sink is ready
   valid_needs_ready: assert property (@(posedge mipi_pclk) disable iff (!rst_n)
      i_wvalid |-> i_wready)
      else $error("wvalid high while wready low");

   last_needs_valid: assert property (@(posedge mipi_pclk) disable iff (!rst_n)
      i_wlast |-> i_wvalid)
      else $error("wlast high without wvalid");

   // Head word holds until it is popped
   head_stable: assert property (@(posedge mipi_pclk) disable iff (!rst_n)
      (!i_empty && !i_wvalid) |=> $stable(i_wdata))
      else $error("FIFO head changed without a pop");

endmodule

bind camera_dma_capture camera_dma_capture_properties u_properties (
   .mipi_pclk (mipi_pclk),
   .rst_n     (rst_n),
   .i_wvalid  (o_dma_wvalid),
   .i_wready  (i_dma_wready),
   .i_wlast   (o_dma_wlast),
   .i_wdata   (o_dma_wdata),
   .i_empty   (o_dma_status[2])
);

//--- hw/camera_dma_capture.sv
////////////////////////////////////////
// Camera DMA capture top level
// Pixel capture, FIFO buffering and DMA
// burst output with status counters
////////////////////////////////////////

`timescale 1ns/1ps

module camera_dma_capture import cam_capture_pkg::*; #(
   parameter int DMA_TRANSFER_LENGTH = DEF_DMA_TRANSFER_LENGTH,
   parameter int PCLK_RATE           = DEF_PCLK_RATE,
   parameter int FIFO_DEPTH          = DEF_FIFO_DEPTH
) (
   input  logic        mipi_pclk,
   input  logic        rst_n,
   input  logic        i_vsync,
   input  logic        i_valid,
   input  pixel_pair_t i_r_pix,
   input  pixel_pair_t i_g_pix,
   input  pixel_pair_t i_b_pix,
   input  logic        i_trigger_capture,
   input  logic        i_continuous_capture,
   input  logic        i_rgb_gray,
   input  logic        i_dma_init_done,
   input  logic        i_dma_wready,
   output logic        o_dma_wvalid,
   output logic        o_dma_wlast,
   output dma_word_t   o_dma_wdata,
   output count_t      o_frames_per_second,
   output count_t      o_fifo_wcount,
   output count_t      o_fifo_rcount,
   output logic        o_fifo_overflow,
   output logic        o_fifo_underflow,
   output logic [2:0]  o_dma_status
);

   logic capture_en;
   logic gray_sel;
   logic vs_fall;
   logic write_active;

   dma_fifo_if fifo_bus ();

   ////////////////////////////////////////
   // Capture front end
   ////////////////////////////////////////

   capture_control u_capture_control (
      .mipi_pclk            (mipi_pclk),
      .rst_n                (rst_n),
      .i_vsync              (i_vsync),
      .i_trigger_capture    (i_trigger_capture),
      .i_continuous_capture (i_continuous_capture),
      .i_rgb_gray           (i_rgb_gray),
      .i_fifo_write         (fifo_bus.wvalid),
      .o_capture_en         (capture_en),
      .o_gray_sel           (gray_sel),
      .o_vs_fall            (vs_fall)
   );

   pixel_formatter u_pixel_formatter (
      .mipi_pclk    (mipi_pclk),
      .rst_n        (rst_n),
      .i_valid      (i_valid),
      .i_r_pix      (i_r_pix),
      .i_g_pix      (i_g_pix),
      .i_b_pix      (i_b_pix),
      .i_capture_en (capture_en),
      .i_gray_sel   (gray_sel),
      .fifo         (fifo_bus.producer)
   );

   ////////////////////////////////////////
   // Buffering and DMA output
   ////////////////////////////////////////

   frame_fifo #(
      .DEPTH (FIFO_DEPTH)
   ) u_frame_fifo (
      .mipi_pclk (mipi_pclk),
      .rst_n     (rst_n),
      .fifo      (fifo_bus.storage)
   );

   dma_burst_writer #(
      .TRANSFER_LENGTH (DMA_TRANSFER_LENGTH)
   ) u_dma_burst_writer (
      .mipi_pclk       (mipi_pclk),
      .rst_n           (rst_n),
      .i_dma_init_done (i_dma_init_done),
      .i_dma_wready    (i_dma_wready),
      .fifo            (fifo_bus.consumer),
      .o_dma_wvalid    (o_dma_wvalid),
      .o_dma_wlast     (o_dma_wlast),
      .o_dma_wdata     (o_dma_wdata),
      .o_write_active  (write_active)
   );

   capture_stats #(
      .PCLK_RATE (PCLK_RATE)
   ) u_capture_stats (
      .mipi_pclk           (mipi_pclk),
      .rst_n               (rst_n),
      .i_vs_fall           (vs_fall),
      .i_write_active      (write_active),
      .i_dma_wready        (i_dma_wready),
      .fifo                (fifo_bus.monitor),
      .o_frames_per_second (o_frames_per_second),
      .o_fifo_wcount       (o_fifo_wcount),
      .o_fifo_rcount       (o_fifo_rcount),
      .o_fifo_overflow     (o_fifo_overflow),
      .o_fifo_underflow    (o_fifo_underflow),
      .o_dma_status        (o_dma_status)
   );

endmodule

//--- hw/capture_stats.sv
////////////////////////////////////////
// Capture statistics
// Frame rate meter, sticky FIFO errors,
// word counters and DMA status
////////////////////////////////////////

`timescale 1ns/1ps

module capture_stats import cam_capture_pkg::*; #(
   parameter int PCLK_RATE = DEF_PCLK_RATE
) (
   input  logic       mipi_pclk,
   input  logic       rst_n,
   input  logic       i_vs_fall,
   input  logic       i_write_active,
   input  logic       i_dma_wready,
   dma_fifo_if.monitor fifo,
   output count_t     o_frames_per_second,
   output count_t     o_fifo_wcount,
   output count_t     o_fifo_rcount,
   output logic       o_fifo_overflow,
   output logic       o_fifo_underflow,
   output logic [2:0] o_dma_status
);

   localparam count_t WINDOW_END = count_t'(PCLK_RATE);

   count_t timer_cnt;
   count_t frame_cnt;
   logic   window_end;

   assign window_end = (timer_cnt == WINDOW_END);

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         timer_cnt           <= '0;
         frame_cnt           <= '0;
         o_frames_per_second <= '0;
         o_fifo_wcount       <= '0;
         o_fifo_rcount       <= '0;
         o_fifo_overflow     <= 1'b0;
         o_fifo_underflow    <= 1'b0;
      end else begin
         // Window of PCLK_RATE+1 clocks, an edge on its last cycle still counts
         timer_cnt <= window_end ? '0 : timer_cnt + 1'b1;
         if (window_end) begin
            o_frames_per_second <= frame_cnt + count_t'(i_vs_fall);
            frame_cnt           <= '0;
         end else if (i_vs_fall) begin
            frame_cnt <= frame_cnt + 1'b1;
         end
         if (fifo.overflow) o_fifo_overflow <= 1'b1;
         if (fifo.underflow) o_fifo_underflow <= 1'b1;
         if (fifo.wvalid) o_fifo_wcount <= o_fifo_wcount + 1'b1;
         if (fifo.re) o_fifo_rcount <= o_fifo_rcount + 1'b1;
      end
   end

   assign o_dma_status = {fifo.empty, i_write_active, i_dma_wready};

endmodule

//--- hw/dma_burst_writer.sv
////////////////////////////////////////
// DMA burst writer
// Armed by DMA ready, drains the FIFO in
// fixed length bursts with wlast
////////////////////////////////////////

`timescale 1ns/1ps

module dma_burst_writer import cam_capture_pkg::*; #(
   parameter int TRANSFER_LENGTH = DEF_DMA_TRANSFER_LENGTH
) (
   input  logic      mipi_pclk,
   input  logic      rst_n,
   input  logic      i_dma_init_done,
   input  logic      i_dma_wready,
   dma_fifo_if.consumer fifo,
   output logic      o_dma_wvalid,
   output logic      o_dma_wlast,
   output dma_word_t o_dma_wdata,
   output logic      o_write_active
);

   localparam int CW = (TRANSFER_LENGTH > 1) ? $clog2(TRANSFER_LENGTH) : 1;
   localparam logic [CW-1:0] LAST_BEAT = CW'(TRANSFER_LENGTH - 1);

   writer_state_t state;
   logic [CW-1:0] beat_cnt;
   logic          init_r1;
   logic          init_r2;
   logic          init_r3;

   // Valid follows ready, so a raised valid always transfers
   assign fifo.re        = (state == BURST) && i_dma_wready && !fifo.empty;
   assign o_dma_wvalid   = fifo.re;
   assign o_dma_wlast    = o_dma_wvalid && (beat_cnt == LAST_BEAT);
   assign o_dma_wdata    = {8'h00, fifo.rdata[47:24], 8'h00, fifo.rdata[23:0]};
   assign o_write_active = (state == BURST);

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         state    <= IDLE;
         beat_cnt <= '0;
         init_r1  <= 1'b0;
         init_r2  <= 1'b0;
         init_r3  <= 1'b0;
      end else begin
         init_r1 <= i_dma_init_done;
         init_r2 <= init_r1;
         init_r3 <= init_r2;
         case (state)
            IDLE: begin
               beat_cnt <= '0;
               if (init_r2 && !init_r3) begin
                  state <= BURST;
               end
            end
            BURST: begin
               if (o_dma_wlast) begin
                  beat_cnt <= '0;
                  state    <= IDLE;
               end else if (o_dma_wvalid) begin
                  beat_cnt <= beat_cnt + 1'b1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

//--- hw/frame_fifo.sv
////////////////////////////////////////
// Frame FIFO
// First-word-fall-through storage with
// overflow and underflow pulses
////////////////////////////////////////

`timescale 1ns/1ps

module frame_fifo import cam_capture_pkg::*; #(
   parameter int DEPTH = DEF_FIFO_DEPTH
) (
   input  logic mipi_pclk,
   input  logic rst_n,
   dma_fifo_if.storage fifo
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam logic [AW-1:0] LAST_ADDR = AW'(DEPTH - 1);
   localparam logic [AW:0]   FULL_CNT  = (AW + 1)'(DEPTH);

   rgb_word_t     mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   fill;
   logic          full;
   logic          do_write;
   logic          do_read;

   assign full       = (fill == FULL_CNT);
   assign fifo.empty = (fill == '0);
   assign do_write   = fifo.wvalid && !full;
   assign do_read    = fifo.re && !fifo.empty;

   // Head word is visible without a read request
   assign fifo.rdata = mem[rd_ptr];

   always_ff @(posedge mipi_pclk) begin
      if (do_write) begin
         mem[wr_ptr] <= fifo.wdata;
      end
   end

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         wr_ptr         <= '0;
         rd_ptr         <= '0;
         fill           <= '0;
         fifo.overflow  <= 1'b0;
         fifo.underflow <= 1'b0;
      end else begin
         if (do_write) begin
            wr_ptr <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + 1'b1;
         end
         if (do_read) begin
            rd_ptr <= (rd_ptr == LAST_ADDR) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_write, do_read})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
         fifo.overflow  <= fifo.wvalid && full;
         fifo.underflow <= fifo.re && fifo.empty;
      end
   end

endmodule

//--- hw/pixel_formatter.sv
////////////////////////////////////////
// Pixel formatter
// Optional grayscale, packs a pixel
// pair into one registered FIFO word
////////////////////////////////////////

`timescale 1ns/1ps

module pixel_formatter import cam_capture_pkg::*; (
   input  logic        mipi_pclk,
   input  logic        rst_n,
   input  logic        i_valid,
   input  pixel_pair_t i_r_pix,
   input  pixel_pair_t i_g_pix,
   input  pixel_pair_t i_b_pix,
   input  logic        i_capture_en,
   input  logic        i_gray_sel,
   dma_fifo_if.producer fifo
);

   // Weighted sum fits 16 bits, keep the top byte
   function automatic pixel_t to_gray(input pixel_t r, input pixel_t g, input pixel_t b);
      logic [15:0] sum;
      sum = GRAY_R_WEIGHT * r + GRAY_G_WEIGHT * g + GRAY_B_WEIGHT * b;
      return sum[15:8];
   endfunction

   pixel_t    gray0;
   pixel_t    gray1;
   rgb_word_t word_next;

   assign gray0 = to_gray(i_r_pix[7:0], i_g_pix[7:0], i_b_pix[7:0]);
   assign gray1 = to_gray(i_r_pix[15:8], i_g_pix[15:8], i_b_pix[15:8]);

   assign word_next = i_gray_sel ? {gray1, gray1, gray1, gray0, gray0, gray0} :
                      {i_b_pix[15:8], i_g_pix[15:8], i_r_pix[15:8],
                       i_b_pix[7:0], i_g_pix[7:0], i_r_pix[7:0]};

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         fifo.wvalid <= 1'b0;
      end else begin
         fifo.wvalid <= i_valid && i_capture_en;
      end
   end

   always_ff @(posedge mipi_pclk) begin
      fifo.wdata <= word_next;
   end

endmodule

//--- hw/capture_control.sv
////////////////////////////////////////
// Capture control
// Syncs the software controls and opens
// capture on whole frames at the vsync
// falling edge
////////////////////////////////////////

`timescale 1ns/1ps

module capture_control import cam_capture_pkg::*; (
   input  logic mipi_pclk,
   input  logic rst_n,
   input  logic i_vsync,
   input  logic i_trigger_capture,
   input  logic i_continuous_capture,
   input  logic i_rgb_gray,
   input  logic i_fifo_write,
   output logic o_capture_en,
   output logic o_gray_sel,
   output logic o_vs_fall
);

   logic vsync_r;
   logic trig_r1;
   logic trig_r2;
   logic trig_r3;
   logic trig_pending;
   logic cont_r1;
   logic cont_r2;
   logic cont_hold;
   logic gray_r1;
   logic gray_r2;
   logic capture_en;

   assign o_vs_fall = vsync_r && !i_vsync;

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         vsync_r      <= 1'b0;
         trig_r1      <= 1'b0;
         trig_r2      <= 1'b0;
         trig_r3      <= 1'b0;
         trig_pending <= 1'b0;
         cont_r1      <= 1'b0;
         cont_r2      <= 1'b0;
         cont_hold    <= 1'b0;
         gray_r1      <= 1'b0;
         gray_r2      <= 1'b0;
         capture_en   <= 1'b0;
      end else begin
         vsync_r <= i_vsync;
         trig_r1 <= i_trigger_capture;
         trig_r2 <= trig_r1;
         trig_r3 <= trig_r2;
         // Single shot waits until the first word of its frame is written
         if (trig_r2 && !trig_r3) begin
            trig_pending <= 1'b1;
         end else if (i_fifo_write) begin
            trig_pending <= 1'b0;
         end
         cont_r1 <= i_continuous_capture;
         cont_r2 <= cont_r1;
         if (cont_r2) begin
            cont_hold <= 1'b1;
         end
         gray_r1 <= i_rgb_gray;
         gray_r2 <= gray_r1;
         // Switch only on frame boundaries
         if ((trig_pending || cont_hold) && o_vs_fall) begin
            capture_en <= 1'b1;
         end else if (capture_en && o_vs_fall && !cont_hold) begin
            capture_en <= 1'b0;
         end
      end
   end

   assign o_capture_en = capture_en;
   assign o_gray_sel   = gray_r2;

endmodule

//--- hw/dma_fifo_if.sv
////////////////////////////////////////
// Formatter to FIFO to DMA writer bus
////////////////////////////////////////

`timescale 1ns/1ps

interface dma_fifo_if import cam_capture_pkg::*; ();

   logic      wvalid;
   rgb_word_t wdata;
   logic      re;
   rgb_word_t rdata;
   logic      empty;
   logic      overflow;
   logic      underflow;

   modport producer (output wvalid, output wdata);
   modport storage  (input wvalid, input wdata, input re,
                     output rdata, output empty, output overflow, output underflow);
   modport consumer (output re, input empty, input rdata);
   // Read only view for the statistics block
   modport monitor  (input wvalid, input re, input overflow, input underflow, input empty);

endinterface

//--- hw/cam_capture_pkg.sv
////////////////////////////////////////
// Camera capture shared definitions
// Pixel and word types, writer states,
// default sizes and gray weights
////////////////////////////////////////

package cam_capture_pkg;

   // One colour or gray sample
   typedef logic [7:0]  pixel_t;
   // Two samples of one channel, pixel 1 in the upper byte
   typedef logic [15:0] pixel_pair_t;
   // FIFO word {b1, g1, r1, b0, g0, r0}
   typedef logic [47:0] rgb_word_t;
   // DMA beat with a zero byte above each 24-bit pixel
   typedef logic [63:0] dma_word_t;
   typedef logic [31:0] count_t;

   typedef enum logic {
      IDLE,
      BURST
   } writer_state_t;

   localparam int DEF_DMA_TRANSFER_LENGTH = 1920;
   localparam int DEF_PCLK_RATE           = 100000000;
   localparam int DEF_FIFO_DEPTH          = 1024;

   // Luma weights, sum is 256
   localparam logic [7:0] GRAY_R_WEIGHT = 8'd77;
   localparam logic [7:0] GRAY_G_WEIGHT = 8'd150;
   localparam logic [7:0] GRAY_B_WEIGHT = 8'd29;

endpackage
